// File: coproc_frontend.f
coproc_pkg.sv
fetch_capture.sv
coproc_predecode.sv
coproc_unit.sv
decode_issue.sv
coproc_frontend_top.sv
tb_coproc_frontend.sv

// File: coproc_frontend_top.sv
`timescale 1ns/1ns

module coproc_frontend_top #(
        parameter int CP_REGS    = 16,
        parameter int CDP_CYCLES = 3
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_flush,
        input  logic                    i_stall,
        input  logic                    i_fetch_valid,
        input  coproc_pkg::fetch_t      i_fetch,
        input  logic                    i_pipeline_dav,
        input  logic [31:0]             i_mcr_data,
        output logic                    o_fetch_stall,
        output logic                    o_issue_valid,
        output coproc_pkg::issue_t      o_issue,
        output logic                    o_cp_result_valid,
        output coproc_pkg::cp_result_t  o_cp_result,
        output logic                    o_cp_undef
);

        logic                fc_valid;
        coproc_pkg::fetch_t  fc_fetch;
        logic                pd_valid;
        coproc_pkg::issue_t  pd_issue;
        logic                pd_stall;
        logic                cp_dav;
        logic [31:0]         cp_word;
        logic                cp_done;

        assign o_fetch_stall = pd_stall;

        fetch_capture fetch_capture_i (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_fetch_valid  (i_fetch_valid),
                .i_fetch        (i_fetch),
                .i_hold         (pd_stall || i_stall),
                .i_flush        (i_flush),
                .o_valid        (fc_valid),
                .o_fetch        (fc_fetch)
        );

        coproc_predecode coproc_predecode_i (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (i_flush),
                .i_stall        (i_stall),
                .i_valid        (fc_valid),
                .i_fetch        (fc_fetch),
                .i_pipeline_dav (i_pipeline_dav),
                .i_cp_done      (cp_done),
                .o_valid        (pd_valid),
                .o_issue        (pd_issue),
                .o_stall        (pd_stall),
                .o_cp_dav       (cp_dav),
                .o_cp_word      (cp_word)
        );

        coproc_unit #(
                .CP_REGS        (CP_REGS),
                .CDP_CYCLES     (CDP_CYCLES)
        ) coproc_unit_i (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_cp_dav       (cp_dav),
                .i_cp_word      (cp_word),
                .i_mcr_data     (i_mcr_data),
                .o_cp_done      (cp_done),
                .o_result_valid (o_cp_result_valid),
                .o_result       (o_cp_result),
                .o_undef        (o_cp_undef)
        );

        // Stalled slot enters decode as a bubble.
        decode_issue decode_issue_i (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (i_flush),
                .i_stall        (i_stall),
                .i_valid        (pd_valid && !pd_stall),
                .i_issue        (pd_issue),
                .o_valid        (o_issue_valid),
                .o_issue        (o_issue)
        );

endmodule

// File: coproc_pkg.sv
package coproc_pkg;

        // Fetched word with the CPSR T bit and interrupt lines.
        typedef struct packed {
                logic [31:0] instr;
                logic        t;
                logic        irq;
                logic        fiq;
        } fetch_t;

        typedef struct packed {
                logic [31:0] instr;
                logic        irq;
                logic        fiq;
        } issue_t;

        typedef enum logic [2:0] {
                CP_NONE,
                CP_CDP,
                CP_MCR,
                CP_MRC,
                CP_LDSTC
        } cp_op_e;

        typedef enum logic [1:0] {
                FN_ADD,
                FN_SUB,
                FN_MOV
        } cdp_fn_e;

        typedef enum logic {
                PD_IDLE,
                PD_BUSY
        } cp_state_e;

        typedef struct packed {
                logic [3:0]  rd;    // Core destination register.
                logic [31:0] value;
        } cp_result_t;

        localparam logic [31:0] NV_INSTR = {4'b1111, 28'd0};

        // Low bit of each 4-bit field.
        localparam int CRM_POS  = 0;
        localparam int CRD_POS  = 12;
        localparam int RD_POS   = 12;
        localparam int CRN_POS  = 16;
        localparam int OPC1_POS = 20;

        // Classifies a word by the ARM coprocessor encodings.
        function automatic cp_op_e decode_op(input logic [31:0] w);
                cp_op_e op;
                op = CP_NONE;
                if (w[27:25] == 3'b110)
                        op = CP_LDSTC;
                else if (w[27:24] == 4'b1110)
                begin
                        if (!w[4])
                                op = CP_CDP;
                        else if (w[20])
                                op = CP_MRC;  // L bit set.
                        else
                                op = CP_MCR;
                end
                return op;
        endfunction

endpackage

// File: coproc_predecode.sv
`timescale 1ns/1ns

module coproc_predecode
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_flush,
        input  logic                i_stall,
        input  logic                i_valid,
        input  coproc_pkg::fetch_t  i_fetch,
        input  logic                i_pipeline_dav,
        input  logic                i_cp_done,
        output logic                o_valid,
        output coproc_pkg::issue_t  o_issue,
        output logic                o_stall,
        output logic                o_cp_dav,
        output logic [31:0]         o_cp_word
);

        coproc_pkg::cp_state_e state;
        coproc_pkg::cp_state_e state_nxt;
        logic                  is_cp;
        logic                  hand_off;
        logic                  done_q;
        logic                  done_any;
        logic                  dav_nxt;

        // Thumb state never yields a coprocessor match.
        assign is_cp = i_valid && !i_fetch.t &&
                       (coproc_pkg::decode_op(i_fetch.instr) != coproc_pkg::CP_NONE);
        assign done_any = i_cp_done || done_q;

        always_comb
        begin
                o_valid       = i_valid;
                o_issue.instr = i_fetch.instr;
                o_issue.irq   = i_fetch.irq;
                o_issue.fiq   = i_fetch.fiq;
                o_stall       = 1'b0;
                hand_off      = 1'b0;
                dav_nxt       = 1'b0;
                state_nxt     = state;

                case (state)
                coproc_pkg::PD_IDLE:
                begin
                        if (is_cp)
                        begin
                                o_valid       = 1'b0;  // Bubble with interrupts masked.
                                o_issue.instr = coproc_pkg::NV_INSTR;
                                o_issue.irq   = 1'b0;
                                o_issue.fiq   = 1'b0;
                                o_stall       = 1'b1;
                                if (!i_pipeline_dav)
                                begin
                                        hand_off  = 1'b1;
                                        dav_nxt   = 1'b1;
                                        state_nxt = coproc_pkg::PD_BUSY;
                                end
                        end
                end
                coproc_pkg::PD_BUSY:
                begin
                        o_valid       = 1'b0;
                        o_issue.instr = coproc_pkg::NV_INSTR;
                        o_issue.irq   = 1'b0;
                        o_issue.fiq   = 1'b0;
                        o_stall       = !done_any;
                        dav_nxt       = o_cp_dav && !done_any;
                        if (done_any)
                                state_nxt = coproc_pkg::PD_IDLE;
                end
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        state    <= coproc_pkg::PD_IDLE;
                        o_cp_dav <= 1'b0;
                        done_q   <= 1'b0;
                end
                else if (!i_stall)
                begin
                        state    <= state_nxt;
                        o_cp_dav <= dav_nxt;
                        done_q   <= 1'b0;
                end
                else
                begin
                        // Done under stall is kept until the stall lifts.
                        if (i_cp_done)
                                o_cp_dav <= 1'b0;
                        if (state == coproc_pkg::PD_BUSY && i_cp_done)
                                done_q <= 1'b1;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (hand_off && !i_stall && !i_flush)
                        o_cp_word <= i_fetch.instr;
        end

endmodule

// File: coproc_unit.sv
`timescale 1ns/1ns

module coproc_unit #(
        parameter int CP_REGS    = 16,
        parameter int CDP_CYCLES = 3
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_cp_dav,
        input  logic [31:0]             i_cp_word,
        input  logic [31:0]             i_mcr_data,
        output logic                    o_cp_done,
        output logic                    o_result_valid,
        output coproc_pkg::cp_result_t  o_result,
        output logic                    o_undef
);

        localparam int MAX_LAT = (CDP_CYCLES > 2) ? CDP_CYCLES : 2;
        localparam int CNT_W   = $clog2(MAX_LAT);
        localparam int IDX_W   = (CP_REGS > 1) ? $clog2(CP_REGS) : 1;

        logic [31:0]          regs [CP_REGS];
        logic                 busy;
        logic [CNT_W-1:0]     cnt;
        logic [CNT_W-1:0]     lat_in;
        logic [31:0]          word;
        coproc_pkg::cp_op_e   op;
        coproc_pkg::cp_op_e   op_in;
        coproc_pkg::cdp_fn_e  fn;
        logic [3:0]           opc1;
        logic [IDX_W-1:0]     crn;
        logic [IDX_W-1:0]     crd;
        logic [IDX_W-1:0]     crm;
        logic [31:0]          cdp_val;

        assign op_in = coproc_pkg::decode_op(i_cp_word);

        always_comb
        begin
                case (op_in)
                coproc_pkg::CP_CDP: lat_in = CNT_W'(CDP_CYCLES - 1);
                coproc_pkg::CP_MRC: lat_in = CNT_W'(1);
                default:            lat_in = '0;
                endcase
        end

        assign opc1 = word[coproc_pkg::OPC1_POS +: 4];
        assign crn  = word[coproc_pkg::CRN_POS +: IDX_W];
        assign crd  = word[coproc_pkg::CRD_POS +: IDX_W];
        assign crm  = word[coproc_pkg::CRM_POS +: IDX_W];

        // Codes past move fall back to move.
        assign fn = (opc1 > 4'd2) ? coproc_pkg::FN_MOV : coproc_pkg::cdp_fn_e'(opc1[1:0]);

        always_comb
        begin
                case (fn)
                coproc_pkg::FN_ADD: cdp_val = regs[crn] + regs[crm];
                coproc_pkg::FN_SUB: cdp_val = regs[crn] - regs[crm];
                default:            cdp_val = regs[crm];
                endcase
        end

        assign o_cp_done      = busy && (cnt == '0);
        assign o_result_valid = o_cp_done && (op == coproc_pkg::CP_MRC);
        assign o_undef        = o_cp_done && (op == coproc_pkg::CP_LDSTC);
        assign o_result.rd    = word[coproc_pkg::RD_POS +: 4];
        assign o_result.value = regs[crn];

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        busy <= 1'b0;
                        cnt  <= '0;
                        for (int i = 0; i < CP_REGS; i++)
                                regs[i] <= '0;
                end
                else if (!busy)
                begin
                        if (i_cp_dav)
                        begin
                                busy <= 1'b1;
                                cnt  <= lat_in;
                                op   <= op_in;
                                word <= i_cp_word;
                        end
                end
                else if (cnt != '0)
                begin
                        cnt <= cnt - 1'b1;
                end
                else
                begin
                        busy <= 1'b0;  // Write back on the done cycle.
                        case (op)
                        coproc_pkg::CP_MCR: regs[crn] <= i_mcr_data;
                        coproc_pkg::CP_CDP: regs[crd] <= cdp_val;
                        default:            ;
                        endcase
                end
        end

endmodule

// File: decode_issue.sv
`timescale 1ns/1ns

module decode_issue
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_flush,
        input  logic                i_stall,
        input  logic                i_valid,
        input  coproc_pkg::issue_t  i_issue,
        output logic                o_valid,
        output coproc_pkg::issue_t  o_issue
);

        // Flush wins over stall.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_valid <= 1'b0;
                end
                else if (i_flush)
                begin
                        o_valid <= 1'b0;
                end
                else if (!i_stall)
                begin
                        o_valid <= i_valid;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (!i_stall)
                begin
                        o_issue <= i_issue;
                end
        end

endmodule

// File: fetch_capture.sv
`timescale 1ns/1ns

module fetch_capture
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_fetch_valid,
        input  coproc_pkg::fetch_t  i_fetch,
        input  logic                i_hold,
        input  logic                i_flush,
        output logic                o_valid,
        output coproc_pkg::fetch_t  o_fetch
);

        // Valid follows the strobe unless held; a held word stays put.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_valid <= 1'b0;
                end
                else if (i_flush)
                begin
                        o_valid <= 1'b0;
                end
                else if (!i_hold)
                begin
                        o_valid <= i_fetch_valid;  // Consumed unless a new one arrives.
                end
        end

        // Strobes during hold are dropped.
        always_ff @(posedge i_clk)
        begin
                if (!i_hold && i_fetch_valid)
                begin
                        o_fetch <= i_fetch;
                end
        end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f coproc_frontend.f \
        --top-module tb_coproc_frontend -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
        exit 0
else
        exit 1
fi

// File: tb_coproc_frontend.sv
`timescale 1ns/1ns

module tb_coproc_frontend;

        localparam int RESET_CYCLES   = 10;
        localparam int PLAIN_COUNT    = 8;
        localparam int RELEASE_LIMIT  = 40;
        localparam int PLAIN_BUDGET   = PLAIN_COUNT * 5;
        localparam int THUMB_BUDGET   = 10;
        localparam int MCR_MRC_BUDGET = 30;
        localparam int CDP_BUDGET     = 100;
        localparam int DRAIN_BUDGET   = 80;
        localparam int MARGIN         = 50;
        localparam int TIMEOUT_CYCLES = RESET_CYCLES + PLAIN_BUDGET + THUMB_BUDGET +
                                        MCR_MRC_BUDGET + CDP_BUDGET + DRAIN_BUDGET + MARGIN;

        logic                    clk;
        logic                    reset;
        logic                    flush;
        logic                    stall;
        logic                    fetch_valid;
        coproc_pkg::fetch_t      fetch;
        logic                    pipeline_dav;
        logic [31:0]             mcr_data;
        logic                    fetch_stall;
        logic                    issue_valid;
        coproc_pkg::issue_t      issue;
        logic                    cp_result_valid;
        coproc_pkg::cp_result_t  cp_result;
        logic                    cp_undef;

        int                      errors;
        int                      checks;
        int                      cycles;
        int                      issue_cnt;
        int                      result_cnt;
        int                      undef_cnt;
        coproc_pkg::cp_result_t  last_result;
        logic [31:0]             cp_model [16];
        logic [31:0]             lfsr_state;

        coproc_frontend_top #(
                .CP_REGS           (16),
                .CDP_CYCLES        (3)
        ) dut_i (
                .i_clk             (clk),
                .i_reset           (reset),
                .i_flush           (flush),
                .i_stall           (stall),
                .i_fetch_valid     (fetch_valid),
                .i_fetch           (fetch),
                .i_pipeline_dav    (pipeline_dav),
                .i_mcr_data        (mcr_data),
                .o_fetch_stall     (fetch_stall),
                .o_issue_valid     (issue_valid),
                .o_issue           (issue),
                .o_cp_result_valid (cp_result_valid),
                .o_cp_result       (cp_result),
                .o_cp_undef        (cp_undef)
        );

        initial
        begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        always @(posedge clk)
        begin
                cycles <= cycles + 1;
                if (cycles >= TIMEOUT_CYCLES)
                begin
                        $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
                        $display("TESTBENCH FAILED");
                        $finish;
                end
        end

        // Strobe counters sampled mid-cycle.
        always @(negedge clk)
        begin
                if (!reset)
                begin
                        if (issue_valid)
                                issue_cnt <= issue_cnt + 1;
                        if (cp_result_valid)
                        begin
                                result_cnt  <= result_cnt + 1;
                                last_result <= cp_result;
                        end
                        if (cp_undef)
                                undef_cnt <= undef_cnt + 1;
                end
        end

        // Galois LFSR stepped once per bit.
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int i = 0; i < n; i++)
                begin
                        v = {v[30:0], lfsr_state[0]};
                        if (lfsr_state[0])
                                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
                        else
                                lfsr_state = lfsr_state >> 1;
                end
                return v;
        endfunction

        function automatic logic [3:0] rand_nibble();
                logic [31:0] v;
                v = rand_bits(4);
                return v[3:0];
        endfunction

        function automatic logic [31:0] mcr_word(input logic [3:0] crn, input logic [3:0] rd);
                return {4'hE, 4'hE, 3'b000, 1'b0, crn, rd, 4'h1, 3'b000, 1'b1, 4'h0};
        endfunction

        function automatic logic [31:0] mrc_word(input logic [3:0] crn, input logic [3:0] rd);
                return {4'hE, 4'hE, 3'b000, 1'b1, crn, rd, 4'h1, 3'b000, 1'b1, 4'h0};
        endfunction

        function automatic logic [31:0] cdp_word(input logic [3:0] opc1, input logic [3:0] crd,
                                                 input logic [3:0] crn, input logic [3:0] crm);
                return {4'hE, 4'hE, opc1, crn, crd, 4'h1, 3'b000, 1'b0, crm};
        endfunction

        task automatic check_issue(input string name, input coproc_pkg::issue_t got,
                                   input coproc_pkg::issue_t exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("ERROR %s: got %h expected %h", name, got, exp);
                end
        endtask

        task automatic check_result(input string name, input coproc_pkg::cp_result_t got,
                                    input coproc_pkg::cp_result_t exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("ERROR %s: got %h expected %h", name, got, exp);
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("ERROR %s: got %h expected %h", name, got, exp);
                end
        endtask

        task automatic send_fetch(input logic [31:0] instr, input logic t,
                                  input logic irq, input logic fiq);
                @(posedge clk);
                #1;
                fetch_valid = 1'b1;
                fetch.instr = instr;
                fetch.t     = t;
                fetch.irq   = irq;
                fetch.fiq   = fiq;
                @(posedge clk);
                #1;
                fetch_valid = 1'b0;
        endtask

        // Pass-through path is two cycles from strobe to issue.
        task automatic run_plain(input logic [31:0] instr, input logic t,
                                 input logic irq, input logic fiq);
                coproc_pkg::issue_t exp;
                exp.instr = instr;
                exp.irq   = irq;
                exp.fiq   = fiq;
                send_fetch(instr, t, irq, fiq);
                check_flag("o_fetch_stall", fetch_stall, 1'b0);
                check_flag("o_issue_valid", issue_valid, 1'b0);
                @(posedge clk);
                #1;
                check_flag("o_issue_valid", issue_valid, 1'b1);
                check_issue("o_issue", issue, exp);
                @(posedge clk);
                #1;
                check_flag("o_issue_valid", issue_valid, 1'b0);
        endtask

        task automatic run_cp(input logic [31:0] instr, input int hold,
                              input logic exp_res, input logic exp_und);
                int issue0;
                int res0;
                int und0;
                int n;
                coproc_pkg::issue_t bubble;
                bubble.instr = coproc_pkg::NV_INSTR;
                bubble.irq   = 1'b0;
                bubble.fiq   = 1'b0;
                issue0       = issue_cnt;
                res0         = result_cnt;
                und0         = undef_cnt;
                pipeline_dav = (hold > 0);
                send_fetch(instr, 1'b0, 1'b1, 1'b1);
                @(negedge clk);
                check_flag("o_fetch_stall", fetch_stall, 1'b1);
                for (n = 0; n < hold; n++)
                begin
                        @(negedge clk);
                        check_flag("o_fetch_stall", fetch_stall, 1'b1);
                end
                if (hold > 0)
                begin
                        @(posedge clk);
                        #1;
                        check_flag("o_cp_result_valid", result_cnt != res0, 1'b0);
                        check_flag("o_cp_undef", undef_cnt != und0, 1'b0);
                        pipeline_dav = 1'b0;  // Pipeline drained.
                end
                n = 0;
                while (fetch_stall && n < RELEASE_LIMIT)
                begin
                        @(negedge clk);
                        n++;
                end
                if (fetch_stall)
                begin
                        errors++;
                        $display("Stall never released for coprocessor word %h", instr);
                end
                @(posedge clk);
                #1;
                check_issue("o_issue", issue, bubble);
                check_flag("o_issue_valid", issue_cnt != issue0, 1'b0);
                check_flag("o_cp_result_valid", result_cnt != res0, exp_res);
                check_flag("o_cp_undef", undef_cnt != und0, exp_und);
        endtask

        task automatic load_register(input logic [3:0] crn, input logic [31:0] data);
                mcr_data = data;
                run_cp(mcr_word(crn, rand_nibble()), 0, 1'b0, 1'b0);
                cp_model[crn] = data;
        endtask

        task automatic read_back_register(input logic [3:0] crn, input int hold);
                coproc_pkg::cp_result_t exp;
                exp.rd    = rand_nibble();
                exp.value = cp_model[crn];
                run_cp(mrc_word(crn, exp.rd), hold, 1'b1, 1'b0);
                check_result("o_cp_result", last_result, exp);
        endtask

        task automatic cdp_op(input logic [3:0] opc1, input logic [3:0] crd,
                              input logic [3:0] crn, input logic [3:0] crm);
                run_cp(cdp_word(opc1, crd, crn, crm), 0, 1'b0, 1'b0);
                case (opc1)
                4'd0:    cp_model[crd] = cp_model[crn] + cp_model[crm];
                4'd1:    cp_model[crd] = cp_model[crn] - cp_model[crm];
                default: cp_model[crd] = cp_model[crm];  // Move also covers codes past 2.
                endcase
        endtask

        task automatic ordinary_instructions();
                logic [31:0] instr;
                for (int i = 0; i < PLAIN_COUNT; i++)
                begin
                        instr        = rand_bits(32);
                        instr[27:26] = 2'b00;  // Data processing class.
                        run_plain(instr, 1'b0, i[0], i[1]);
                end
        endtask

        task automatic thumb_passthrough();
                run_plain(mcr_word(4'd5, 4'd2), 1'b1, 1'b1, 1'b0);
                run_plain(cdp_word(4'd0, 4'd1, 4'd2, 4'd3), 1'b1, 1'b0, 1'b1);
        endtask

        task automatic mcr_then_mrc();
                logic [3:0] crn;
                crn = rand_nibble();
                load_register(crn, rand_bits(32));
                read_back_register(crn, 0);
        endtask

        task automatic cdp_arithmetic();
                load_register(4'd1, rand_bits(32));
                load_register(4'd2, rand_bits(32));
                cdp_op(4'd0, 4'd3, 4'd1, 4'd2);
                read_back_register(4'd3, 0);
                cdp_op(4'd1, 4'd4, 4'd1, 4'd2);
                read_back_register(4'd4, 0);
                cdp_op(4'd2, 4'd5, 4'd0, 4'd2);
                read_back_register(4'd5, 0);
                cdp_op(4'd9, 4'd6, 4'd0, 4'd1);
                read_back_register(4'd6, 0);
        endtask

        task automatic drain_undef_flush();
                read_back_register(4'd3, 8);
                run_cp(32'hED90_1100, 0, 1'b0, 1'b1);  // LDC.
                pipeline_dav = 1'b1;
                @(posedge clk);
                #1;
                fetch_valid = 1'b1;
                fetch.instr = 32'hE081_0002;  // ADD r0, r1, r2.
                fetch.t     = 1'b0;
                fetch.irq   = 1'b0;
                fetch.fiq   = 1'b0;
                @(posedge clk);
                #1;
                fetch.instr = cdp_word(4'd2, 4'd3, 4'd0, 4'd1);
                fetch.irq   = 1'b1;
                @(posedge clk);
                #1;
                fetch_valid = 1'b0;
                stall       = 1'b1;  // Holds the issued ADD behind the pending CDP.
                @(posedge clk);
                #1;
                check_flag("o_fetch_stall", fetch_stall, 1'b1);
                check_flag("o_issue_valid", issue_valid, 1'b1);
                flush = 1'b1;  // Flush beats stall.
                @(posedge clk);
                #1;
                flush = 1'b0;
                stall = 1'b0;
                check_flag("o_fetch_stall", fetch_stall, 1'b0);
                check_flag("o_issue_valid", issue_valid, 1'b0);
                pipeline_dav = 1'b0;
                repeat (3) @(posedge clk);
                #1;
                check_flag("cp_dav", dut_i.cp_dav, 1'b0);
                read_back_register(4'd3, 0);  // Flushed CDP left CR3 alone.
        endtask

        initial
        begin
                errors       = 0;
                checks       = 0;
                lfsr_state   = 32'h384d_02c6;
                reset        = 1'b1;
                flush        = 1'b0;
                stall        = 1'b0;
                fetch_valid  = 1'b0;
                fetch        = '0;
                pipeline_dav = 1'b0;
                mcr_data     = '0;
                for (int i = 0; i < 16; i++)
                        cp_model[i] = '0;
                repeat (RESET_CYCLES) @(posedge clk);
                #1;
                reset = 1'b0;
                check_flag("o_fetch_stall", fetch_stall, 1'b0);
                check_flag("o_issue_valid", issue_valid, 1'b0);
                check_flag("o_cp_result_valid", cp_result_valid, 1'b0);
                check_flag("o_cp_undef", cp_undef, 1'b0);
                check_flag("cp_dav", dut_i.cp_dav, 1'b0);

                ordinary_instructions();
                thumb_passthrough();
                mcr_then_mrc();
                cdp_arithmetic();
                drain_undef_flush();

                $display("Checks run: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("TESTBENCH PASSED");
                else
                        $display("TESTBENCH FAILED");
                $finish;
        end

endmodule
